// ==== list.f ====
common/axi_mem_pkg.sv
common/axi_bus_if.sv
common/mem_req_if.sv
axi2mem/axi2mem.sv
src/sram_bank.sv
src/axi_sram_top.sv
verification/tb_axi_sram.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then look for the fail message in the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_axi_sram -f list.f -o tb_axi_sram \
    && ./obj_dir/tb_axi_sram 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

// ==== verification/tb_axi_sram.sv ====
`timescale 1ns/1ps

module tb_axi_sram
    import axi_mem_pkg::*;
();

    localparam int ID_W       = 4;
    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 32;
    localparam int USER_W     = 4;
    localparam int MEM_WORDS  = 256;
    localparam int BYTES      = DATA_W / 8;
    localparam int OFFS       = $clog2(BYTES);
    localparam int CLK_PERIOD = 4;
    // bursts per test
    localparam int FILL_N  = 16;
    localparam int INCR_N  = 8;
    localparam int WRAP_N  = 4;
    localparam int STRB_N  = 4;
    localparam int BP_N    = 4;
    localparam int ID_N    = 4;
    localparam int FIXED_N = 2;
    // every burst is written and read back once
    localparam int XFERS = 2 * (FILL_N + INCR_N + WRAP_N + STRB_N + BP_N + ID_N + FIXED_N);
    // up to 16 beats per burst, 8 cycles allowed per beat
    localparam int WATCHDOG_NS = XFERS * 16 * 8 * CLK_PERIOD + 16 * CLK_PERIOD;

    logic                clk_i;
    logic                rst_ni;
    logic [ID_W-1:0]     ar_id_i;
    logic [ADDR_W-1:0]   ar_addr_i;
    logic [3:0]          ar_len_i;
    logic [2:0]          ar_size_i;
    logic [1:0]          ar_burst_i;
    logic                ar_valid_i;
    logic                ar_ready_o;
    logic [DATA_W-1:0]   r_data_o;
    logic [ID_W-1:0]     r_id_o;
    logic [1:0]          r_resp_o;
    logic                r_last_o;
    logic [USER_W-1:0]   r_user_o;
    logic                r_valid_o;
    logic                r_ready_i;
    logic [ID_W-1:0]     aw_id_i;
    logic [ADDR_W-1:0]   aw_addr_i;
    logic [3:0]          aw_len_i;
    logic [2:0]          aw_size_i;
    logic [1:0]          aw_burst_i;
    logic                aw_valid_i;
    logic                aw_ready_o;
    logic [DATA_W-1:0]   w_data_i;
    logic [BYTES-1:0]    w_strb_i;
    logic                w_last_i;
    logic [USER_W-1:0]   w_user_i;
    logic                w_valid_i;
    logic                w_ready_o;
    logic [ID_W-1:0]     b_id_o;
    logic [1:0]          b_resp_o;
    logic [USER_W-1:0]   b_user_o;
    logic                b_valid_o;
    logic                b_ready_i;

    // reference copy of the bank contents
    logic [DATA_W-1:0] model_data [MEM_WORDS];
    logic [USER_W-1:0] model_user [MEM_WORDS];

    logic [31:0] lfsr_q = 32'd21;
    string       cur_test;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;

    axi_sram_top #(
        .ID_WIDTH  (ID_W),
        .ADDR_WIDTH(ADDR_W),
        .DATA_WIDTH(DATA_W),
        .USER_WIDTH(USER_W),
        .MEM_WORDS (MEM_WORDS)
    ) DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // random source and address rules
    // --------------------------------------------------
    // galois LFSR, x^32 + x^31 + x^29 + x + 1
    function automatic logic next_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'hD000_0001;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // byte address of beat i of a burst
    function automatic logic [ADDR_W-1:0] beat_addr(input logic [ADDR_W-1:0] start,
                                                    input logic [3:0] len,
                                                    input logic [1:0] burst, input int i);
        logic [ADDR_W-1:0] base;
        int                span;
        if (burst == WRAP) begin
            base = ADDR_W'(get_wrap_boundary(ADDR_MAX'(start), len, OFFS));
            span = (int'(len) + 1) * BYTES;
            // offset inside the window wraps back to the base
            return base + ADDR_W'((int'(start - base) + i * BYTES) % span);
        end
        // INCR and FIXED both step one word per beat
        return start + ADDR_W'(i * BYTES);
    endfunction

    function automatic int word_idx(input logic [ADDR_W-1:0] a);
        return int'(a >> OFFS) % MEM_WORDS;
    endfunction

    task automatic model_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                               input logic [BYTES-1:0] s, input logic [USER_W-1:0] u);
        int idx;
        idx = word_idx(a);
        for (int b = 0; b < BYTES; b++) begin
            if (s[b]) begin
                model_data[idx][8*b +: 8] = d[8*b +: 8];
            end
        end
        model_user[idx] = u;
    endtask

    // --------------------------------------------------
    // reporting
    // --------------------------------------------------
    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("error %s: %s expected %h actual %h", cur_test, what, exp, act);
        test_errs++;
    endtask

    task automatic report_fault(input string msg);
        $display("%s: %s", cur_test, msg);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s finished, no errors", cur_test);
        end else begin
            tests_failed++;
            $display("test %s finished, %0d errors", cur_test, test_errs);
        end
    endtask

    // --------------------------------------------------
    // AXI master tasks
    // --------------------------------------------------
    // mode 0 random data, mode 1 random strobes, mode 2 fill pattern
    task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                               input logic [3:0] len, input logic [1:0] burst,
                               input int mode, input int late, input logic slow_b);
        logic [DATA_W-1:0] dat [16];
        logic [BYTES-1:0]  stb [16];
        logic [USER_W-1:0] usr [16];
        logic [ADDR_W-1:0] a;
        int                beat;
        int                wait_w;
        logic              aw_done;
        logic              b_seen;
        // payload fixed up front, held until each beat is taken
        for (int i = 0; i <= int'(len); i++) begin
            a = beat_addr(addr, len, burst, i);
            if (mode == 2) begin
                // pattern built from the whole address
                dat[i] = {~a, a};
                usr[i] = a[5:2];
                stb[i] = '1;
            end else begin
                dat[i] = rand_bits(DATA_W);
                usr[i] = USER_W'(rand_bits(USER_W));
                stb[i] = (mode == 1) ? BYTES'(rand_bits(BYTES)) : '1;
                if (stb[i] == '0) begin
                    stb[i] = BYTES'(1);
                end
            end
        end
        beat    = 0;
        wait_w  = late;
        aw_done = 1'b0;
        while (beat <= int'(len)) begin
            @(negedge clk_i);
            aw_valid_i = !aw_done;
            aw_id_i    = id;
            aw_addr_i  = addr;
            aw_len_i   = len;
            aw_size_i  = 3'(OFFS);
            aw_burst_i = burst;
            if (wait_w > 0) begin
                w_valid_i = 1'b0;
                wait_w--;
            end else begin
                w_valid_i = 1'b1;
                w_data_i  = dat[beat];
                w_strb_i  = stb[beat];
                w_user_i  = usr[beat];
                w_last_i  = (beat == int'(len));
            end
            // sample just ahead of the rising edge
            #1;
            if (b_valid_o) begin
                report_fault("b_valid came up before the last write beat");
            end
            if (aw_valid_i && aw_ready_o) begin
                aw_done = 1'b1;
            end
            if (w_valid_i && w_ready_o) begin
                model_write(beat_addr(addr, len, burst, beat), dat[beat], stb[beat], usr[beat]);
                beat++;
            end
        end
        b_seen = 1'b0;
        while (!b_seen) begin
            @(negedge clk_i);
            aw_valid_i = 1'b0;
            w_valid_i  = 1'b0;
            w_last_i   = 1'b0;
            b_ready_i  = slow_b ? next_bit() : 1'b1;
            #1;
            if (b_valid_o && b_ready_i) begin
                b_seen = 1'b1;
                if (b_id_o !== id) report_mismatch("b_id", 32'(id), 32'(b_id_o));
                if (b_resp_o !== OKAY) report_mismatch("b_resp", 32'(OKAY), 32'(b_resp_o));
                if (b_user_o !== usr[len]) report_mismatch("b_user", 32'(usr[len]), 32'(b_user_o));
            end
        end
        // exactly one response per burst
        @(negedge clk_i);
        b_ready_i = 1'b0;
        #1;
        if (b_valid_o) begin
            report_fault("a second B response followed the write burst");
        end
    endtask

    task automatic read_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                              input logic [3:0] len, input logic [1:0] burst,
                              input logic slow_r);
        int   beat;
        int   idx;
        logic ar_done;
        ar_done = 1'b0;
        while (!ar_done) begin
            @(negedge clk_i);
            ar_valid_i = 1'b1;
            ar_id_i    = id;
            ar_addr_i  = addr;
            ar_len_i   = len;
            ar_size_i  = 3'(OFFS);
            ar_burst_i = burst;
            r_ready_i  = 1'b0;
            #1;
            ar_done = ar_ready_o;
        end
        beat = 0;
        while (beat <= int'(len)) begin
            @(negedge clk_i);
            ar_valid_i = 1'b0;
            // random back-pressure when asked for
            r_ready_i  = slow_r ? next_bit() : 1'b1;
            #1;
            if (r_valid_o && r_ready_i) begin
                idx = word_idx(beat_addr(addr, len, burst, beat));
                if (r_data_o !== model_data[idx]) begin
                    report_mismatch("r_data", model_data[idx], r_data_o);
                end
                if (r_user_o !== model_user[idx]) begin
                    report_mismatch("r_user", 32'(model_user[idx]), 32'(r_user_o));
                end
                if (r_last_o !== (beat == int'(len))) begin
                    report_mismatch("r_last", 32'(beat == int'(len)), 32'(r_last_o));
                end
                if (r_id_o !== id) report_mismatch("r_id", 32'(id), 32'(r_id_o));
                if (r_resp_o !== OKAY) report_mismatch("r_resp", 32'(OKAY), 32'(r_resp_o));
                beat++;
            end
        end
        // no extra beat after r_last
        @(negedge clk_i);
        r_ready_i = 1'b0;
        #1;
        if (r_valid_o) begin
            report_fault("r_valid stayed high after the last read beat");
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] base;
        logic [3:0]        len;
        rst_ni     = 1'b0;
        ar_id_i    = '0;
        ar_addr_i  = '0;
        ar_len_i   = '0;
        ar_size_i  = 3'(OFFS);
        ar_burst_i = INCR;
        ar_valid_i = 1'b0;
        r_ready_i  = 1'b0;
        aw_id_i    = '0;
        aw_addr_i  = '0;
        aw_len_i   = '0;
        aw_size_i  = 3'(OFFS);
        aw_burst_i = INCR;
        aw_valid_i = 1'b0;
        w_data_i   = '0;
        w_strb_i   = '0;
        w_last_i   = 1'b0;
        w_user_i   = '0;
        w_valid_i  = 1'b0;
        b_ready_i  = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        total_errs   = 0;
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;

        // known background in every word, 16 words per burst
        start_test("fill");
        for (int i = 0; i < FILL_N; i++) begin
            write_burst(ID_W'(rand_bits(ID_W)), ADDR_W'(i * 64), 4'd15, INCR, 2, 0, 1'b0);
        end
        for (int i = 0; i < FILL_N; i++) begin
            read_burst(ID_W'(rand_bits(ID_W)), ADDR_W'(i * 64), 4'd15, INCR, 1'b0);
        end
        finish_test();

        start_test("incr");
        for (int i = 0; i < INCR_N; i++) begin
            id   = ID_W'(rand_bits(ID_W));
            addr = ADDR_W'(rand_bits(ADDR_W - OFFS) << OFFS);
            len  = 4'(rand_bits(4));
            write_burst(id, addr, len, INCR, 0, 0, 1'b0);
            read_burst(id, addr, len, INCR, 1'b0);
        end
        finish_test();

        // windows of 2, 4, 8 and 16 beats, entered halfway
        start_test("wrap");
        for (int i = 0; i < WRAP_N; i++) begin
            id   = ID_W'(rand_bits(ID_W));
            len  = 4'((2 << i) - 1);
            addr = ADDR_W'(rand_bits(ADDR_W - OFFS) << OFFS);
            base = ADDR_W'(get_wrap_boundary(ADDR_MAX'(addr), len, OFFS));
            addr = base + ADDR_W'(((int'(len) + 1) / 2) * BYTES);
            write_burst(id, addr, len, WRAP, 0, 0, 1'b0);
            read_burst(id, base, len, INCR, 1'b0);
        end
        finish_test();

        start_test("strobe");
        for (int i = 0; i < STRB_N; i++) begin
            id   = ID_W'(rand_bits(ID_W));
            addr = ADDR_W'(rand_bits(ADDR_W - OFFS) << OFFS);
            len  = 4'(rand_bits(4));
            write_burst(id, addr, len, INCR, 1, 0, 1'b0);
            read_burst(id, addr, len, INCR, 1'b0);
        end
        finish_test();

        // late w_valid, random r_ready and b_ready
        start_test("stall");
        for (int i = 0; i < BP_N; i++) begin
            id   = ID_W'(rand_bits(ID_W));
            addr = ADDR_W'(rand_bits(ADDR_W - OFFS) << OFFS);
            len  = 4'(rand_bits(4));
            write_burst(id, addr, len, INCR, 0, 1 + int'(rand_bits(2)), 1'b1);
            read_burst(id, addr, len, INCR, 1'b1);
        end
        finish_test();

        start_test("id_echo");
        for (int i = 0; i < ID_N; i++) begin
            id   = ID_W'(rand_bits(ID_W));
            addr = ADDR_W'(rand_bits(ADDR_W - OFFS) << OFFS);
            len  = 4'(rand_bits(2));
            write_burst(id, addr, len, INCR, 0, 0, 1'b1);
            read_burst(~id, addr, len, INCR, 1'b0);
        end
        finish_test();

        // FIXED steps like INCR in this design
        start_test("fixed");
        for (int i = 0; i < FIXED_N; i++) begin
            id   = ID_W'(rand_bits(ID_W));
            addr = ADDR_W'(rand_bits(ADDR_W - OFFS) << OFFS);
            len  = 4'(rand_bits(4));
            write_burst(id, addr, len, FIXED, 0, 0, 1'b0);
            read_burst(id, addr, len, INCR, 1'b0);
        end
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog, sized from the number of bursts
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: %s did not complete within %0d ns", cur_test, WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== src/axi_sram_top.sv ====
`timescale 1ns/1ps

module axi_sram_top
    import axi_mem_pkg::*;
#(
    parameter int ID_WIDTH   = 4,
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32,
    parameter int USER_WIDTH = 4,
    parameter int MEM_WORDS  = 256
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // read address
    input  logic [ID_WIDTH-1:0]     ar_id_i,
    input  logic [ADDR_WIDTH-1:0]   ar_addr_i,
    input  logic [LEN_WIDTH-1:0]    ar_len_i,
    input  logic [SIZE_WIDTH-1:0]   ar_size_i,
    input  logic [1:0]              ar_burst_i,
    input  logic                    ar_valid_i,
    output logic                    ar_ready_o,
    // read data
    output logic [DATA_WIDTH-1:0]   r_data_o,
    output logic [ID_WIDTH-1:0]     r_id_o,
    output logic [1:0]              r_resp_o,
    output logic                    r_last_o,
    output logic [USER_WIDTH-1:0]   r_user_o,
    output logic                    r_valid_o,
    input  logic                    r_ready_i,
    // write address
    input  logic [ID_WIDTH-1:0]     aw_id_i,
    input  logic [ADDR_WIDTH-1:0]   aw_addr_i,
    input  logic [LEN_WIDTH-1:0]    aw_len_i,
    input  logic [SIZE_WIDTH-1:0]   aw_size_i,
    input  logic [1:0]              aw_burst_i,
    input  logic                    aw_valid_i,
    output logic                    aw_ready_o,
    // write data
    input  logic [DATA_WIDTH-1:0]   w_data_i,
    input  logic [DATA_WIDTH/8-1:0] w_strb_i,
    input  logic                    w_last_i,
    input  logic [USER_WIDTH-1:0]   w_user_i,
    input  logic                    w_valid_i,
    output logic                    w_ready_o,
    // write response
    output logic [ID_WIDTH-1:0]     b_id_o,
    output logic [1:0]              b_resp_o,
    output logic [USER_WIDTH-1:0]   b_user_o,
    output logic                    b_valid_o,
    input  logic                    b_ready_i
);

    axi_bus_if #(
        .ID_WIDTH  (ID_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH),
        .USER_WIDTH(USER_WIDTH)
    ) axi ();

    mem_req_if #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH),
        .USER_WIDTH(USER_WIDTH)
    ) mem ();

    // --------------------------------------------------
    // master side of the bus from the plain ports
    // --------------------------------------------------
    assign axi.ar_id    = ar_id_i;
    assign axi.ar_addr  = ar_addr_i;
    assign axi.ar_len   = ar_len_i;
    assign axi.ar_size  = ar_size_i;
    assign axi.ar_burst = axi_burst_t'(ar_burst_i);
    assign axi.ar_valid = ar_valid_i;
    assign axi.r_ready  = r_ready_i;
    assign axi.aw_id    = aw_id_i;
    assign axi.aw_addr  = aw_addr_i;
    assign axi.aw_len   = aw_len_i;
    assign axi.aw_size  = aw_size_i;
    assign axi.aw_burst = axi_burst_t'(aw_burst_i);
    assign axi.aw_valid = aw_valid_i;
    assign axi.w_data   = w_data_i;
    assign axi.w_strb   = w_strb_i;
    assign axi.w_last   = w_last_i;
    assign axi.w_user   = w_user_i;
    assign axi.w_valid  = w_valid_i;
    assign axi.b_ready  = b_ready_i;

    // slave side back out
    assign ar_ready_o = axi.ar_ready;
    assign r_data_o   = axi.r_data;
    assign r_id_o     = axi.r_id;
    assign r_resp_o   = axi.r_resp;
    assign r_last_o   = axi.r_last;
    assign r_user_o   = axi.r_user;
    assign r_valid_o  = axi.r_valid;
    assign aw_ready_o = axi.aw_ready;
    assign w_ready_o  = axi.w_ready;
    assign b_id_o     = axi.b_id;
    assign b_resp_o   = axi.b_resp;
    assign b_user_o   = axi.b_user;
    assign b_valid_o  = axi.b_valid;

    // --------------------------------------------------
    // adapter and memory
    // --------------------------------------------------
    axi2mem #(
        .ID_WIDTH  (ID_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH),
        .USER_WIDTH(USER_WIDTH)
    ) u_axi2mem (
        .clk_i (clk_i),
        .rst_ni(rst_ni),
        .slave (axi.slave),
        .mem   (mem.adapter)
    );

    sram_bank #(
        .MEM_WORDS (MEM_WORDS),
        .DATA_WIDTH(DATA_WIDTH),
        .USER_WIDTH(USER_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_sram_bank (
        .clk_i(clk_i),
        .mem  (mem.bank)
    );

endmodule

// ==== src/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank #(
    parameter int MEM_WORDS  = 256,
    parameter int DATA_WIDTH = 32,
    parameter int USER_WIDTH = 4,
    parameter int ADDR_WIDTH = 16
) (
    input logic     clk_i,
    mem_req_if.bank mem
);

    localparam int BYTES     = DATA_WIDTH / 8;
    localparam int OFFS      = $clog2(BYTES);
    localparam int IDX_WIDTH = $clog2(MEM_WORDS);

    // word storage plus one user tag per word
    logic [DATA_WIDTH-1:0] data_q [MEM_WORDS];
    logic [USER_WIDTH-1:0] user_q [MEM_WORDS];

    logic [ADDR_WIDTH-1:0] word_addr;
    logic [IDX_WIDTH-1:0]  idx;

    // byte address to word index, folded onto the array size
    assign word_addr = mem.addr >> OFFS;
    assign idx       = IDX_WIDTH'(word_addr % ADDR_WIDTH'(MEM_WORDS));

    always_ff @(posedge clk_i) begin
        if (mem.req) begin
            if (mem.we) begin
                // only the lanes picked by be change
                for (int b = 0; b < BYTES; b++) begin
                    if (mem.be[b]) begin
                        data_q[idx][8*b +: 8] <= mem.wdata[8*b +: 8];
                    end
                end
                user_q[idx] <= mem.wuser;
            end
            // read port, valid the cycle after req
            mem.rdata <= data_q[idx];
            mem.ruser <= user_q[idx];
        end
    end

    // a write with no byte lane set is never issued
    assert property (@(posedge clk_i) (mem.req && mem.we) |-> mem.be != '0);

endmodule

// ==== axi2mem/axi2mem.sv ====
`timescale 1ns/1ps

module axi2mem
    import axi_mem_pkg::*;
#(
    parameter int ID_WIDTH   = 4,
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32,
    parameter int USER_WIDTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    axi_bus_if.slave   slave,
    mem_req_if.adapter mem
);

    localparam int BYTES = DATA_WIDTH / 8;
    localparam int OFFS  = $clog2(BYTES);

    typedef enum logic [2:0] {
        IDLE,
        READ,
        WRITE,
        WAIT_WVALID,
        SEND_B
    } state_t;

    // address phase fields, held for the whole burst
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        axi_burst_t            burst;
    } ax_t;

    state_t                state_d, state_q;
    ax_t                   ax_d, ax_q;
    logic [LEN_WIDTH-1:0]  cnt_d, cnt_q;
    logic [ADDR_WIDTH-1:0] req_addr_d, req_addr_q;
    logic [USER_WIDTH-1:0] buser_d, buser_q;

    logic [ADDR_WIDTH-1:0] wrap_base;
    logic [ADDR_WIDTH-1:0] wrap_top;
    logic [ADDR_WIDTH-1:0] incr_addr;
    logic [ADDR_WIDTH-1:0] nxt_addr;
    logic                  rd_last;

    // --------------------------------------------------
    // next address
    // --------------------------------------------------
    // req_addr_q holds the address of the current beat
    assign wrap_base = ADDR_WIDTH'(get_wrap_boundary(ADDR_MAX'(ax_q.addr), ax_q.len, OFFS));
    // first address past the window, may overflow at the top of memory
    assign wrap_top  = wrap_base + ((ADDR_WIDTH'(ax_q.len) + ADDR_WIDTH'(1)) << OFFS);
    assign incr_addr = req_addr_q + ADDR_WIDTH'(BYTES);
    // FIXED steps the same way as INCR
    // WRAP folds back to the base once it hits the window top
    assign nxt_addr  = (ax_q.burst == WRAP && incr_addr == wrap_top) ? wrap_base : incr_addr;

    // beat counter reaches len on the last read beat
    assign rd_last = (cnt_q == ax_q.len);

    // --------------------------------------------------
    // response payload
    // --------------------------------------------------
    // read data comes straight from the bank output register
    assign slave.r_data = mem.rdata;
    assign slave.r_user = mem.ruser;
    assign slave.r_id   = ax_q.id;
    assign slave.r_resp = OKAY;
    assign slave.r_last = rd_last;
    // b carries the user tag of the final write beat
    assign slave.b_id   = ax_q.id;
    assign slave.b_resp = OKAY;
    assign slave.b_user = buser_q;

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_comb begin
        state_d    = state_q;
        ax_d       = ax_q;
        cnt_d      = cnt_q;
        req_addr_d = req_addr_q;
        buser_d    = buser_q;
        // memory side, write payload passes through
        mem.req    = 1'b0;
        mem.we     = 1'b0;
        mem.addr   = req_addr_q;
        mem.be     = slave.w_strb;
        mem.wdata  = slave.w_data;
        mem.wuser  = slave.w_user;
        // handshakes
        slave.ar_ready = 1'b0;
        slave.aw_ready = 1'b0;
        slave.w_ready  = 1'b0;
        slave.r_valid  = 1'b0;
        slave.b_valid  = 1'b0;

        case (state_q)
            IDLE: begin
                // reads take priority over writes
                if (slave.ar_valid) begin
                    slave.ar_ready = 1'b1;
                    ax_d       = '{slave.ar_id, slave.ar_addr, slave.ar_len, slave.ar_burst};
                    // fetch beat 0 right away
                    mem.req    = 1'b1;
                    mem.addr   = slave.ar_addr;
                    req_addr_d = slave.ar_addr;
                    cnt_d      = '0;
                    state_d    = READ;
                end else if (slave.aw_valid) begin
                    slave.aw_ready = 1'b1;
                    slave.w_ready  = 1'b1;
                    ax_d     = '{slave.aw_id, slave.aw_addr, slave.aw_len, slave.aw_burst};
                    mem.addr = slave.aw_addr;
                    // overridden below when beat 0 is already here
                    state_d  = WAIT_WVALID;
                end
            end

            READ: begin
                slave.r_valid = 1'b1;
                // without r_ready the same word is read again
                mem.req = 1'b1;
                if (slave.r_ready) begin
                    cnt_d      = cnt_q + 1'b1;
                    req_addr_d = nxt_addr;
                    mem.addr   = nxt_addr;
                    if (rd_last) begin
                        mem.req = 1'b0;
                        state_d = IDLE;
                    end
                end
            end

            WAIT_WVALID: begin
                // beat 0 still outstanding
                slave.w_ready = 1'b1;
                mem.addr      = ax_q.addr;
            end

            WRITE: begin
                slave.w_ready = 1'b1;
                mem.addr      = nxt_addr;
            end

            SEND_B: begin
                slave.b_valid = 1'b1;
                if (slave.b_ready) begin
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // one write beat per w handshake, for every write state
        if (slave.w_ready && slave.w_valid) begin
            mem.req    = 1'b1;
            mem.we     = 1'b1;
            req_addr_d = mem.addr;
            buser_d    = slave.w_user;
            state_d    = slave.w_last ? SEND_B : WRITE;
        end
    end

    // --------------------------------------------------
    // assertions
    // --------------------------------------------------
    // full-width beats only
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        slave.ar_valid |-> slave.ar_size == SIZE_WIDTH'(OFFS));
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        slave.aw_valid |-> slave.aw_size == SIZE_WIDTH'(OFFS));

    // start addresses must be word aligned
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        slave.ar_valid |-> slave.ar_addr[OFFS-1:0] == '0);
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        slave.aw_valid |-> slave.aw_addr[OFFS-1:0] == '0);

    // a latched wrap burst must be 2, 4, 8 or 16 beats long
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q != IDLE && ax_q.burst == WRAP) |-> ax_q.len inside {4'd1, 4'd3, 4'd7, 4'd15});

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // burst payload, only read while a burst is active
    always_ff @(posedge clk_i) begin
        ax_q       <= ax_d;
        req_addr_q <= req_addr_d;
        buser_q    <= buser_d;
    end

endmodule

// ==== common/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32,
    parameter int USER_WIDTH = 4
);

    // request side, no handshake, the bank takes every request
    logic                    req;
    logic                    we;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH/8-1:0] be;
    logic [DATA_WIDTH-1:0]   wdata;
    logic [USER_WIDTH-1:0]   wuser;
    // read return, valid one cycle after the request
    logic [DATA_WIDTH-1:0]   rdata;
    logic [USER_WIDTH-1:0]   ruser;

    modport adapter (output req, we, addr, be, wdata, wuser, input rdata, ruser);

    modport bank (input req, we, addr, be, wdata, wuser, output rdata, ruser);

endinterface

// ==== common/axi_bus_if.sv ====
`timescale 1ns/1ps

interface axi_bus_if
    import axi_mem_pkg::*;
#(
    parameter int ID_WIDTH   = 4,
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32,
    parameter int USER_WIDTH = 4
);

    // read address channel
    logic [ID_WIDTH-1:0]     ar_id;
    logic [ADDR_WIDTH-1:0]   ar_addr;
    logic [LEN_WIDTH-1:0]    ar_len;
    logic [SIZE_WIDTH-1:0]   ar_size;
    axi_burst_t              ar_burst;
    logic                    ar_valid;
    logic                    ar_ready;
    // read data channel
    logic [ID_WIDTH-1:0]     r_id;
    logic [DATA_WIDTH-1:0]   r_data;
    axi_resp_t               r_resp;
    logic                    r_last;
    logic [USER_WIDTH-1:0]   r_user;
    logic                    r_valid;
    logic                    r_ready;
    // write address channel
    logic [ID_WIDTH-1:0]     aw_id;
    logic [ADDR_WIDTH-1:0]   aw_addr;
    logic [LEN_WIDTH-1:0]    aw_len;
    logic [SIZE_WIDTH-1:0]   aw_size;
    axi_burst_t              aw_burst;
    logic                    aw_valid;
    logic                    aw_ready;
    // write data channel
    logic [DATA_WIDTH-1:0]   w_data;
    logic [DATA_WIDTH/8-1:0] w_strb;
    logic                    w_last;
    logic [USER_WIDTH-1:0]   w_user;
    logic                    w_valid;
    logic                    w_ready;
    // write response channel
    logic [ID_WIDTH-1:0]     b_id;
    axi_resp_t               b_resp;
    logic [USER_WIDTH-1:0]   b_user;
    logic                    b_valid;
    logic                    b_ready;

    modport master (
        output ar_id, ar_addr, ar_len, ar_size, ar_burst, ar_valid, input ar_ready,
        input r_id, r_data, r_resp, r_last, r_user, r_valid, output r_ready,
        output aw_id, aw_addr, aw_len, aw_size, aw_burst, aw_valid, input aw_ready,
        output w_data, w_strb, w_last, w_user, w_valid, input w_ready,
        input b_id, b_resp, b_user, b_valid, output b_ready
    );

    modport slave (
        input ar_id, ar_addr, ar_len, ar_size, ar_burst, ar_valid, output ar_ready,
        output r_id, r_data, r_resp, r_last, r_user, r_valid, input r_ready,
        input aw_id, aw_addr, aw_len, aw_size, aw_burst, aw_valid, output aw_ready,
        input w_data, w_strb, w_last, w_user, w_valid, output w_ready,
        output b_id, b_resp, b_user, b_valid, input b_ready
    );

endinterface

// ==== common/axi_mem_pkg.sv ====
package axi_mem_pkg;

    // ax_len field width, bursts of up to 16 beats
    localparam int LEN_WIDTH  = 4;
    // ax_size field width
    // the field holds log2 of the bytes moved per beat
    localparam int SIZE_WIDTH = 3;
    // widest address the wrap helper works on
    localparam int ADDR_MAX   = 64;

    // burst type encoding
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_t;

    // response encoding, only OKAY is ever returned here
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // lowest address of the wrap window that holds addr
    // the window is len+1 beats wide
    // legal wrap lengths are 1, 3, 7 and 15
    function automatic logic [ADDR_MAX-1:0] get_wrap_boundary(
        input logic [ADDR_MAX-1:0]  addr,
        input logic [LEN_WIDTH-1:0] len,
        input int unsigned          offs_bits
    );
        int unsigned win_bits;
        case (len)
            4'd1:    win_bits = offs_bits + 1;
            4'd3:    win_bits = offs_bits + 2;
            4'd7:    win_bits = offs_bits + 3;
            4'd15:   win_bits = offs_bits + 4;
            // not a wrap length, only strip the byte offset
            default: win_bits = offs_bits;
        endcase
        return addr & ({ADDR_MAX{1'b1}} << win_bits);
    endfunction

endpackage
